//--- fetch_pkg.sv
// Fetch path definitions
// Describes the block that arrives from fetch and the record that the
// aligner hands to the decode stage for each issued instruction
`default_nettype none

package fetch_pkg;

  // Bytes delivered by one fetch pulse
  localparam int FETCH_BYTES = 8;

  // One fetched block, byte 0 is at the lowest address
  typedef struct packed {
    logic [FETCH_BYTES-1:0][7:0] data;
  } fetch_blk_t;

  // ==================================================
  // Issue record
  // ==================================================

  // Instruction with zero fill past its length, the length itself and
  // the address of the opcode byte
  typedef struct packed {
    isa_pkg::instruction_t ins;
    isa_pkg::ins_len_t     len;
    logic [31:0]           pc;
  } issue_t;

endpackage

`default_nettype wire

//--- fetch_queue.sv
// Byte queue between fetch and the aligner
// Takes 8-byte fetch blocks at its tail, drops consumed instructions
// from its head and presents the lowest bytes as an instruction window
`timescale 1ns/1ns
`default_nettype none

module fetch_queue #(
  parameter int QUEUE_BYTES = 16
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               fill,
  input  fetch_pkg::fetch_blk_t              fill_blk,
  input  logic                               consume,
  input  isa_pkg::ins_len_t                  consume_len,
  output isa_pkg::instruction_t              head_bytes,
  output logic [$clog2(QUEUE_BYTES+1)-1:0]   head_count,
  output logic                               space_ok
);

  import isa_pkg::*;
  import fetch_pkg::*;

  localparam int CW = $clog2(QUEUE_BYTES + 1);
  localparam int BW = QUEUE_BYTES * 8;

  // Byte 0 of the queue sits in bits 7:0, the head is always there
  logic [BW-1:0] q_r;
  logic [CW-1:0] count_r;

  logic [BW-1:0] q_nxt;
  logic [CW-1:0] cnt_nxt;
  logic [BW-1:0] kept;
  logic [BW-1:0] blk_ext;
  logic [CW-1:0] drop;
  logic          take;

  // ==================================================
  // Next state
  // ==================================================

  assign blk_ext = {{(BW - 8*FETCH_BYTES){1'b0}}, fill_blk.data};

  // Consume is applied first, so a new block lands right behind the
  // bytes that survive this cycle
  always_comb begin
    drop = consume ? CW'(consume_len) : '0;
    take = fill && space_ok;

    // Shifting right pulls zeros in at the top
    kept    = q_r >> {drop, 3'b000};
    q_nxt   = kept;
    cnt_nxt = count_r - drop;

    if (take) begin
      q_nxt   = kept | (blk_ext << {cnt_nxt, 3'b000});
      cnt_nxt = cnt_nxt + CW'(FETCH_BYTES);
    end
  end

  // Bytes above count_r stay zero, which lets a new block be OR-ed in
  // and makes the window read zero past the valid bytes
  always_ff @(posedge clk) begin
    if (rst) begin
      q_r     <= '0;
      count_r <= '0;
    end else begin
      q_r     <= q_nxt;
      count_r <= cnt_nxt;
    end
  end

  // ==================================================
  // Outputs
  // ==================================================

  assign head_bytes = q_r[8*MAX_INS_BYTES-1:0];
  assign head_count = count_r;

  // Room for one more block, judged on the registered count alone
  assign space_ok = (count_r <= CW'(QUEUE_BYTES - FETCH_BYTES));

endmodule

`default_nettype wire

//--- filelist.f
isa_pkg.sv
fetch_pkg.sv
ins_length.sv
fetch_queue.sv
ins_align.sv
ifetch_top.sv
ifetch_props.sv
tb_ifetch.sv

//--- ifetch_props.sv
// Concurrent checks on the instruction fetch front end
// Bound into the top level, watches reset, issue and fetch handshakes
`timescale 1ns/1ns
`default_nettype none

module ifetch_props (
  input logic              clk,
  input logic              rst,
  input logic              stall,
  input logic              fetch_valid,
  input logic              fetch_ready,
  input logic              ins_valid,
  input fetch_pkg::issue_t ins_out
);

  // The aligner register is cleared by reset
  a_idle_after_reset: assert property (@(posedge clk) rst |=> !ins_valid)
    else $error("ins_valid high in the cycle after reset");

  // Only the four encodable sizes can leave the aligner
  a_len_legal: assert property (@(posedge clk) disable iff (rst)
    ins_valid |-> (ins_out.len inside {4'd2, 4'd4, 4'd6, 4'd8}))
    else $error("issued length %0d is not a legal size", ins_out.len);

  // A stalled edge consumes nothing, so nothing shows up after it
  a_stall_blocks_issue: assert property (@(posedge clk) disable iff (rst)
    stall |=> !ins_valid)
    else $error("instruction issued after a stalled edge");

  // The fetch source may only pulse while the queue has room
  a_fetch_when_ready: assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> fetch_ready)
    else $error("fetch_valid pulsed while fetch_ready was low");

endmodule

bind ifetch_top ifetch_props u_props (
  .clk         (clk),
  .rst         (rst),
  .stall       (stall),
  .fetch_valid (fetch_valid),
  .fetch_ready (fetch_ready),
  .ins_valid   (ins_valid),
  .ins_out     (ins_out)
);

`default_nettype wire

//--- ifetch_top.sv
// Instruction fetch alignment front end
// Fetch blocks enter a byte queue, the length decoder sizes the head
// instruction and the aligner issues it with its program counter
`timescale 1ns/1ns
`default_nettype none

module ifetch_top #(
  parameter int          QUEUE_BYTES = 16,
  parameter logic [31:0] RESET_PC    = 32'h0000_1000
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fetch_valid,
  input  fetch_pkg::fetch_blk_t fetch_blk,
  input  logic                  stall,
  output logic                  fetch_ready,
  output logic                  ins_valid,
  output fetch_pkg::issue_t     ins_out
);

  import isa_pkg::*;

  // Queue head as seen by the decoder and the aligner
  instruction_t                     head_bytes;
  logic [$clog2(QUEUE_BYTES+1)-1:0] head_count;
  ins_len_t                         len;

  // Aligner back to the queue
  logic     consume;
  ins_len_t consume_len;

  fetch_queue #(
    .QUEUE_BYTES (QUEUE_BYTES)
  ) u_queue (
    .clk         (clk),
    .rst         (rst),
    .fill        (fetch_valid),
    .fill_blk    (fetch_blk),
    .consume     (consume),
    .consume_len (consume_len),
    .head_bytes  (head_bytes),
    .head_count  (head_count),
    .space_ok    (fetch_ready)
  );

  ins_length u_length (
    .ir  (head_bytes),
    .len (len)
  );

  ins_align #(
    .QUEUE_BYTES (QUEUE_BYTES),
    .RESET_PC    (RESET_PC)
  ) u_align (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .head_bytes  (head_bytes),
    .head_count  (head_count),
    .len         (len),
    .consume     (consume),
    .consume_len (consume_len),
    .ins_valid   (ins_valid),
    .ins_out     (ins_out)
  );

endmodule

`default_nettype wire

//--- ins_align.sv
// Instruction aligner
// Issues one whole instruction per cycle from the queue head, clears
// the bytes past its length and tracks the program counter
`timescale 1ns/1ns
`default_nettype none

module ins_align #(
  parameter int          QUEUE_BYTES = 16,
  parameter logic [31:0] RESET_PC    = 32'h0000_1000
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             stall,
  input  isa_pkg::instruction_t            head_bytes,
  input  logic [$clog2(QUEUE_BYTES+1)-1:0] head_count,
  input  isa_pkg::ins_len_t                len,
  output logic                             consume,
  output isa_pkg::ins_len_t                consume_len,
  output logic                             ins_valid,
  output fetch_pkg::issue_t                ins_out
);

  import isa_pkg::*;

  localparam int CW = $clog2(QUEUE_BYTES + 1);

  logic [31:0]  pc_r;
  instruction_t filled;

  // The head is complete once the queue holds every byte the decoder
  // asked for
  assign consume     = !stall && (head_count >= CW'(len));
  assign consume_len = len;

  // Bytes of the following instruction are cleared through the byte view
  always_comb begin
    filled = head_bytes;
    for (int i = 0; i < MAX_INS_BYTES; i++) begin
      if (i >= int'(len))
        filled.bytes[i] = 8'h00;
    end
  end

  // ==================================================
  // Issue registers
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      ins_valid <= 1'b0;
      pc_r      <= RESET_PC;
    end else begin
      ins_valid <= consume;
      if (consume)
        pc_r <= pc_r + 32'(len);
    end
  end

  // Issue record is only meaningful while ins_valid is high
  always_ff @(posedge clk) begin
    if (consume) begin
      ins_out.ins <= filled;
      ins_out.len <= len;
      ins_out.pc  <= pc_r;
    end
  end

endmodule

`default_nettype wire

//--- ins_length.sv
// Instruction length decoder
// Looks at the opcode byte of the instruction at the queue head and
// returns how many bytes the instruction occupies, purely combinational
`timescale 1ns/1ns
`default_nettype none

module ins_length (
  input  isa_pkg::instruction_t ir,
  output isa_pkg::ins_len_t     len
);

  import isa_pkg::*;

  // ==================================================
  // Opcode table
  // ==================================================

  // Only the opcode field matters here, the payload is ignored
  always_comb begin
    case (ir.any.opcode) inside
      // Short forms with no immediate
      BRK, NOP, RTS, RTE, SYNC, EXI7:
        len = 4'd2;

      // Register plus short immediate, and the compact loads and stores
      ADDI, ANDI, ORI, XORI, MULI, CMPI:
        len = 4'd4;
      MOV, SYS, LDOS, STOS, EXI23:
        len = 4'd4;

      // Long immediate arithmetic
      ADDIL, ANDIL, ORIL, XORIL:
        len = 4'd6;

      // Two source register ops and CSR access
      R2, CSR:
        len = 4'd6;

      // Loads and stores with a full displacement
      LDB, LDW, LDO, STB, STW, STO:
        len = 4'd6;

      // Mid size constant extension
      EXI41:
        len = 4'd6;

      // Largest constant extension fills the whole window
      EXI55:
        len = 4'd8;

      // All conditional and decrement branches share one encoding size
      [BRANCH_LO:BRANCH_HI]:
        len = 4'd6;

      // Upper block of six byte extended ops
      [EXT6_LO:EXT6_HI]:
        len = 4'd6;

      // Anything unlisted is treated as a two byte op, so an undefined
      // opcode still moves the stream forward
      default:
        len = 4'd2;
    endcase
  end

endmodule

`default_nettype wire

//--- isa_pkg.sv
// Instruction set definitions for the variable-length front end
// Holds the opcode values, the instruction word with its two views,
// and the length type shared by the length decoder and the aligner
`default_nettype none

package isa_pkg;

  // ==================================================
  // Basic sizes and types
  // ==================================================

  // Longest instruction in bytes, also the width of the head window
  localparam int MAX_INS_BYTES = 8;

  // Opcode byte, always the lowest byte of an instruction
  typedef logic [7:0] opcode_t;

  // Instruction length in bytes, only 2, 4, 6 and 8 occur
  typedef logic [3:0] ins_len_t;

  // The aligner sees the word as bytes and the decoder sees it as fields
  typedef union packed {
    logic [MAX_INS_BYTES-1:0][7:0] bytes;
    struct packed {
      logic [8*MAX_INS_BYTES-9:0] payload;
      opcode_t                    opcode;
    } any;
  } instruction_t;

  // ==================================================
  // Opcode values
  // ==================================================

  // Two byte forms
  localparam opcode_t BRK   = 8'h00;
  localparam opcode_t EXI7  = 8'h50;
  localparam opcode_t NOP   = 8'hF1;
  localparam opcode_t RTS   = 8'hF2;
  localparam opcode_t RTE   = 8'hF3;
  localparam opcode_t SYNC  = 8'hF7;

  // Four byte forms with a short immediate
  localparam opcode_t ADDI  = 8'h04;
  localparam opcode_t MULI  = 8'h06;
  localparam opcode_t ANDI  = 8'h08;
  localparam opcode_t ORI   = 8'h09;
  localparam opcode_t XORI  = 8'h0A;
  localparam opcode_t CMPI  = 8'h4B;
  localparam opcode_t EXI23 = 8'h51;
  localparam opcode_t LDOS  = 8'h87;
  localparam opcode_t STOS  = 8'h8F;
  localparam opcode_t SYS   = 8'hA5;
  localparam opcode_t MOV   = 8'hA7;

  // Six byte forms, long immediates and the memory ops
  localparam opcode_t R2    = 8'h02;
  localparam opcode_t CSR   = 8'h0F;
  localparam opcode_t ADDIL = 8'h44;
  localparam opcode_t ANDIL = 8'h48;
  localparam opcode_t ORIL  = 8'h49;
  localparam opcode_t XORIL = 8'h4A;
  localparam opcode_t EXI41 = 8'h52;
  localparam opcode_t LDB   = 8'h80;
  localparam opcode_t LDW   = 8'h82;
  localparam opcode_t LDO   = 8'h86;
  localparam opcode_t STB   = 8'h88;
  localparam opcode_t STW   = 8'h89;
  localparam opcode_t STO   = 8'h8B;

  // The only eight byte form, a 55 bit constant extension
  localparam opcode_t EXI55 = 8'h53;

  // Opcode ranges that are all six bytes long
  localparam opcode_t BRANCH_LO = 8'h20;
  localparam opcode_t BRANCH_HI = 8'h3F;
  localparam opcode_t EXT6_LO   = 8'hD0;
  localparam opcode_t EXT6_HI   = 8'hEF;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build the fetch front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_ifetch -f filelist.f -o sim_ifetch

if ! ./obj_dir/sim_ifetch > sim.log 2>&1; then
  cat sim.log
  echo "run.sh: simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
echo "run.sh: simulation clean"

//--- tb_ifetch.sv
// Testbench for the instruction fetch front end
// Builds a random stream of 2 to 8 byte instructions, feeds it in 8-byte
// blocks with random gaps and stalls, and checks every issued instruction
`timescale 1ns/1ns
`default_nettype none

module tb_ifetch;

  import isa_pkg::*;
  import fetch_pkg::*;

  localparam int          QUEUE_BYTES = 16;
  localparam logic [31:0] RESET_PC    = 32'h0000_1000;

  // Every named opcode of the instruction set
  localparam opcode_t NAMED_OPS [31] = '{
    BRK, NOP, RTS, RTE, SYNC, EXI7,
    ADDI, ANDI, ORI, XORI, MULI, CMPI, MOV, SYS, LDOS, STOS, EXI23,
    ADDIL, ANDIL, ORIL, XORIL, R2, CSR, LDB, LDW, LDO, STB, STW, STO, EXI41,
    EXI55
  };

  logic       clk;
  logic       rst;
  logic       fetch_valid;
  fetch_blk_t fetch_blk;
  logic       stall;
  logic       fetch_ready;
  logic       ins_valid;
  issue_t     ins_out;

  logic [31:0] lfsr = 32'h3557;
  logic [7:0]  byte_q [$];
  issue_t      exp_q [$];
  logic [31:0] gen_pc = RESET_PC;
  bit          feed_en = 1'b0;
  logic        stall_seen = 1'b0;
  // fetch_ready as it stood at the last falling edge
  logic        ready_seen = 1'b0;
  int          sent_bytes = 0;
  int          issued_bytes = 0;
  int          checked = 0;
  int          errors = 0;

  ifetch_top #(
    .QUEUE_BYTES (QUEUE_BYTES),
    .RESET_PC    (RESET_PC)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_blk   (fetch_blk),
    .stall       (stall),
    .fetch_ready (fetch_ready),
    .ins_valid   (ins_valid),
    .ins_out     (ins_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // Random source and reference model
  // ==================================================

  // Galois LFSR that steps once for each bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Instruction size for an opcode by the two ranges and then the named table
  function automatic ins_len_t ref_len(input opcode_t op);
    if (op >= 8'h20 && op <= 8'h3F)
      return 4'd6;
    if (op >= 8'hD0 && op <= 8'hEF)
      return 4'd6;
    case (op)
      ADDI, ANDI, ORI, XORI, MULI, CMPI, MOV, SYS, LDOS, STOS, EXI23:
        return 4'd4;
      ADDIL, ANDIL, ORIL, XORIL, R2, CSR, LDB, LDW, LDO, STB, STW, STO, EXI41:
        return 4'd6;
      EXI55:
        return 4'd8;
      default:
        return 4'd2;
    endcase
  endfunction

  // Appends instructions to the byte stream and the expected issue list.
  // NOP padding rounds the stream up to whole fetch blocks
  task automatic gen_stream(input int n_ins);
    opcode_t      op;
    ins_len_t     len;
    instruction_t w;
    issue_t       e;
    int           total;
    total = 0;
    for (int k = 0; k < n_ins || total % 8 != 0; k++) begin
      if (k >= n_ins) begin
        op = NOP;
      end else begin
        case (int'(rand_bits(3)))
          0, 1, 2, 3: op = NAMED_OPS[5'(int'(rand_bits(5)) % 31)];
          4:          op = 8'h20 + 8'(rand_bits(5));
          5:          op = 8'hD0 + 8'(rand_bits(5));
          6:          op = EXI55;
          default:    op = 8'(rand_bits(8));
        endcase
      end
      len = ref_len(op);
      w = '0;
      w.bytes[0] = op;
      byte_q.push_back(op);
      for (int i = 1; i < int'(len); i++) begin
        w.bytes[3'(i)] = 8'(rand_bits(8));
        byte_q.push_back(w.bytes[3'(i)]);
      end
      e.ins = w;
      e.len = len;
      e.pc  = gen_pc;
      exp_q.push_back(e);
      gen_pc = gen_pc + 32'(len);
      total  = total + int'(len);
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================

  // One process drives stall and the fetch blocks. A pulse is always
  // followed by an idle cycle, so fetch_ready is judged after the fill
  initial begin
    fetch_blk_t blk;
    int         gap;
    int         stall_left;
    gap        = 0;
    stall_left = 0;
    fetch_valid <= 1'b0;
    fetch_blk   <= '0;
    stall       <= 1'b0;
    forever begin
      @(posedge clk);
      stall_seen = stall;
      if (fetch_valid && !rst)
        sent_bytes = sent_bytes + 8;
      if (rst || !feed_en) begin
        fetch_valid <= 1'b0;
        stall       <= 1'b0;
        stall_left  = 0;
      end else begin
        // Short random stall bursts
        if (stall_left > 0) begin
          stall_left--;
          stall <= 1'b1;
        end else if (rand_bits(4) == 32'd0) begin
          stall_left = int'(rand_bits(2));
          stall <= 1'b1;
        end else begin
          stall <= 1'b0;
        end
        if (fetch_valid) begin
          fetch_valid <= 1'b0;
          gap = int'(rand_bits(2));
        end else if (gap > 0) begin
          gap--;
        end else if (ready_seen && byte_q.size() >= 8) begin
          for (int i = 0; i < 8; i++)
            blk.data[3'(i)] = byte_q.pop_front();
          fetch_blk   <= blk;
          fetch_valid <= 1'b1;
        end
      end
    end
  end

  // ==================================================
  // Checking
  // ==================================================

  task automatic report_mismatch(input string name, input logic [63:0] want,
                                 input logic [63:0] got);
    $display("FAIL %s: expected %h, actual %h", name, want, got);
    errors++;
  endtask

  task automatic check_issue();
    issue_t e;
    if (stall_seen) begin
      $display("ERROR: instruction at pc %h issued after a stalled edge", ins_out.pc);
      errors++;
    end
    if (exp_q.size() == 0) begin
      $display("ERROR: issue at pc %h with no instruction left in the stream", ins_out.pc);
      errors++;
      issued_bytes = issued_bytes + int'(ref_len(ins_out.ins.any.opcode));
    end else begin
      // Stream order, length, pc chain and zero fill all follow from the list
      e = exp_q.pop_front();
      if (ins_out.len != e.len)
        report_mismatch("length", 64'(e.len), 64'(ins_out.len));
      if (ins_out.pc != e.pc)
        report_mismatch("pc", 64'(e.pc), 64'(ins_out.pc));
      if (ins_out.ins != e.ins)
        report_mismatch("ins", 64'(e.ins), 64'(ins_out.ins));
      issued_bytes = issued_bytes + int'(e.len);
    end
    checked++;
  endtask

  // Outputs are registered, so the falling edge sees them settled
  initial begin
    forever begin
      @(negedge clk);
      ready_seen = fetch_ready;
      if (!rst) begin
        if (ins_valid)
          check_issue();
        // Bytes held in the queue are those sent and not yet issued
        if (fetch_ready && (QUEUE_BYTES - (sent_bytes - issued_bytes)) < 8) begin
          $display("ERROR: fetch_ready high with only %0d free queue bytes",
                   QUEUE_BYTES - (sent_bytes - issued_bytes));
          errors++;
        end
      end
    end
  end

  task automatic wait_drain(input string name);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: timeout in %s with %0d instructions not issued", name, exp_q.size());
      errors++;
    end
  endtask

  task automatic wait_issues(input int n);
    int cycles;
    int base;
    cycles = 0;
    base   = checked;
    while (checked < base + n && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (checked < base + n) begin
      $display("ERROR: timeout waiting for %0d issues before the reset", n);
      errors++;
    end
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Long stream with stalls, gaps and straddling instructions
    @(negedge clk);
    gen_stream(200);
    feed_en = 1'b1;
    wait_drain("long stream");

    // Second stream is cut short by a reset while bytes are queued
    gen_stream(60);
    wait_issues(10);
    feed_en = 1'b0;
    @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    byte_q.delete();
    exp_q.delete();
    sent_bytes   = 0;
    issued_bytes = 0;
    gen_pc       = RESET_PC;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // With the queue empty after reset nothing may issue
    repeat (8) begin
      @(negedge clk);
      if (ins_valid) begin
        $display("ERROR: ins_valid high after reset with no new blocks");
        errors++;
      end
    end

    // Fresh stream restarting at the reset pc
    gen_stream(150);
    feed_en = 1'b1;
    wait_drain("stream after reset");
    feed_en = 1'b0;
    repeat (4) @(negedge clk);

    $display("checked %0d instructions, %0d errors", checked, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire
